// File: counters_defines.svh
// Performance counter widths, counter count, CSR addresses and timer prescale
`ifndef COUNTERS_DEFINES_SVH
`define COUNTERS_DEFINES_SVH

`define XLEN              32        // One machine word
`define COUNTERS          8         // cycle, unused, instret and five events

////////////////////////////////////////
// CSR address map
////////////////////////////////////////
`define MHPMCOUNTER_BASE  12'hB00   // Machine counters, low halves
`define MHPMCOUNTERH_BASE 12'hB80   // Machine counters, high halves
`define HPMCOUNTER_BASE   12'hC00   // User aliases, low halves
`define HPMCOUNTERH_BASE  12'hC80   // User aliases, high halves
`define TIME_ADR          12'hC01   // Shadow of mtime, low word
`define TIMEH_ADR         12'hC81   // Shadow of mtime, high word

// Counter control registers
`define MCOUNTINHIBIT_ADR 12'h320
`define MCOUNTEREN_ADR    12'h306
`define SCOUNTEREN_ADR    12'h106

`define TIMER_DIVIDE      4         // Core cycles per mtime tick

`endif

// File: logic/counterPkg.sv
// Shared types for the performance counter block: privilege, CSR port, event strobes
`default_nettype none

`include "counters_defines.svh"

package counterPkg;

  // Privilege levels as carried on the CSR port
  typedef enum logic [1:0] {
    privUser       = 2'd0,
    privSupervisor = 2'd1,
    privMachine    = 2'd3
  } privModeT;

  // One CSR access, read and write share the address
  typedef struct packed {
    logic              writeEn;    // Write strobe
    logic [11:0]       adr;        // CSR address
    logic [`XLEN-1:0]  writeData;  // Value to write
    privModeT          priv;       // Mode of the access
  } csrAccessT;

  // Strobes from the M stage of the pipeline
  typedef struct packed {
    logic instrValid;
    logic stallW;
    logic flushW;
    logic branchDirWrong;  // Direction mispredict
  } pipeEventsT;

  // Cache strobes, iCacheAccess has no counter slot
  typedef struct packed {
    logic dCacheAccess;
    logic dCacheMiss;
    logic iCacheAccess;
    logic iCacheMiss;
  } cacheEventsT;

  ////////////////////////////////////////
  // Counter slots
  ////////////////////////////////////////
  localparam int cycleIdx        = 0;
  localparam int unusedIdx       = 1;  // Stays zero
  localparam int instretIdx      = 2;
  localparam int loadStallIdx    = 3;
  localparam int branchDirIdx    = 4;
  localparam int dCacheAccessIdx = 5;
  localparam int dCacheMissIdx   = 6;
  localparam int iCacheMissIdx   = 7;

endpackage

`default_nettype wire

// File: logic/eventSource.sv
// Event source: aligns pipeline and cache strobes into one bit per counter slot
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module eventSource (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   stallE,
  input  wire logic                   stallM,
  input  wire logic                   flushM,
  input  wire logic                   loadStallD,
  input  wire counterPkg::pipeEventsT  pipe,
  input  wire counterPkg::cacheEventsT cache,
  output logic [`COUNTERS-1:0]        counterEvent
);

  logic loadStallE;            // Load stall seen in E
  logic loadStallM;            // Load stall seen in M, counted from here
  logic instrValidNotFlushed;  // Instruction really retiring

  ////////////////////////////////////////
  // Load stall pipeline, D to E to M
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      loadStallE <= 1'b0;
    end else if (!stallE) begin  // Hold while E is stalled
      loadStallE <= loadStallD;
    end
  end

  // Flush wins over stall here
  always_ff @(posedge clk) begin
    if (reset || flushM) begin
      loadStallM <= 1'b0;
    end else if (!stallM) begin
      loadStallM <= loadStallE;
    end
  end

  assign instrValidNotFlushed = pipe.instrValid & ~pipe.stallW & ~pipe.flushW;

  ////////////////////////////////////////
  // Slot mapping
  ////////////////////////////////////////
  always_comb begin
    counterEvent = '0;
    counterEvent[counterPkg::cycleIdx]        = 1'b1;  // Every cycle
    counterEvent[counterPkg::unusedIdx]       = 1'b0;  // Reserved slot
    counterEvent[counterPkg::instretIdx]      = instrValidNotFlushed;
    // Not gated by flush, the stall itself is the event
    counterEvent[counterPkg::loadStallIdx]    = loadStallM;
    counterEvent[counterPkg::branchDirIdx]    = pipe.branchDirWrong & instrValidNotFlushed;
    // Cache strobes come straight from the caches
    counterEvent[counterPkg::dCacheAccessIdx] = cache.dCacheAccess;
    counterEvent[counterPkg::dCacheMissIdx]   = cache.dCacheMiss;
    counterEvent[counterPkg::iCacheMissIdx]   = cache.iCacheMiss;
  end

endmodule

`default_nettype wire

// File: logic/counterControl.sv
// Counter control registers: inhibit mask plus machine and supervisor enable masks
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module counterControl (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire counterPkg::csrAccessT csr,
  output logic [`COUNTERS-1:0]       inhibitMask,
  output logic [`COUNTERS-1:0]       mEnableMask,
  output logic [`COUNTERS-1:0]       sEnableMask
);

  logic writeInhibit;  // mcountinhibit write
  logic writeMEnable;  // mcounteren write
  logic writeSEnable;  // scounteren write

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  assign writeInhibit = csr.writeEn & (csr.adr == `MCOUNTINHIBIT_ADR);
  assign writeMEnable = csr.writeEn & (csr.adr == `MCOUNTEREN_ADR);
  assign writeSEnable = csr.writeEn & (csr.adr == `SCOUNTEREN_ADR);

  // Only the implemented low bits are kept
  always_ff @(posedge clk) begin
    if (reset) begin
      inhibitMask <= '0;  // All counters run out of reset
    end else if (writeInhibit) begin
      inhibitMask <= csr.writeData[`COUNTERS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mEnableMask <= '0;  // Lower modes locked out
    end else if (writeMEnable) begin
      mEnableMask <= csr.writeData[`COUNTERS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sEnableMask <= '0;
    end else if (writeSEnable) begin
      sEnableMask <= csr.writeData[`COUNTERS-1:0];
    end
  end

endmodule

`default_nettype wire

// File: logic/counterBank.sv
// Counter bank: eight 64-bit counters kept as low and high words, with CSR writes
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module counterBank (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire counterPkg::csrAccessT csr,
  input  wire logic [`COUNTERS-1:0]  counterEvent,
  input  wire logic [`COUNTERS-1:0]  inhibitMask,
  output logic [`XLEN-1:0]           counterLow  [`COUNTERS],
  output logic [`XLEN-1:0]           counterHigh [`COUNTERS]
);

  localparam int CountW = 2 * `XLEN;  // Full counter width

  // Aligned bases, slot number added below
  localparam logic [11:0] LowBase  = `MHPMCOUNTER_BASE;
  localparam logic [11:0] HighBase = `MHPMCOUNTERH_BASE;

  logic [`COUNTERS-1:0] writeLow;   // Per slot low word write
  logic [`COUNTERS-1:0] writeHigh;  // Per slot high word write
  logic [`COUNTERS-1:0] countEn;    // Event and not inhibited
  logic [CountW-1:0]    countPlus [`COUNTERS];

  ////////////////////////////////////////
  // One counter per slot
  ////////////////////////////////////////
  for (genvar i = 0; i < `COUNTERS; i++) begin : gCounter

    // Write strobes for both halves
    assign writeLow[i]  = csr.writeEn & (csr.adr == LowBase + 12'(i));
    assign writeHigh[i] = csr.writeEn & (csr.adr == HighBase + 12'(i));

    assign countEn[i] = counterEvent[i] & ~inhibitMask[i];

    // 64-bit add so the low word carries into the high word
    assign countPlus[i] = {counterHigh[i], counterLow[i]} + CountW'(countEn[i]);

    always_ff @(posedge clk) begin
      if (reset) begin
        counterLow[i]  <= '0;
        counterHigh[i] <= '0;
      end else begin
        // A written half takes the data, the other keeps counting
        counterLow[i]  <= writeLow[i] ? csr.writeData : countPlus[i][`XLEN-1:0];
        counterHigh[i] <= writeHigh[i] ? csr.writeData
                                       : countPlus[i][CountW-1:`XLEN];
      end
    end

  end

endmodule

`default_nettype wire

// File: logic/counterRead.sv
// Counter read side: privilege check and read mux over counters, time and masks
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module counterRead (
  input  wire counterPkg::csrAccessT csr,
  input  wire logic [`XLEN-1:0]      counterLow  [`COUNTERS],
  input  wire logic [`XLEN-1:0]      counterHigh [`COUNTERS],
  input  wire logic [63:0]           mtime,
  input  wire logic [`COUNTERS-1:0]  inhibitMask,
  input  wire logic [`COUNTERS-1:0]  mEnableMask,
  input  wire logic [`COUNTERS-1:0]  sEnableMask,
  output logic [`XLEN-1:0]           readData,
  output logic                       illegalAccess
);

  localparam int IdxW = $clog2(`COUNTERS);

  localparam logic [11:0] MLowBase  = `MHPMCOUNTER_BASE;
  localparam logic [11:0] MHighBase = `MHPMCOUNTERH_BASE;
  localparam logic [11:0] ULowBase  = `HPMCOUNTER_BASE;
  localparam logic [11:0] UHighBase = `HPMCOUNTERH_BASE;

  logic [IdxW-1:0]  idx;          // Slot, also the enable bit
  logic [`XLEN-1:0] readValue;    // Value before the privilege check
  logic             known;        // Address is implemented
  logic             machineOnly;  // No lower mode access
  logic             allowed;

  assign idx = csr.adr[IdxW-1:0];

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_comb begin
    readValue   = '0;
    known       = 1'b1;
    machineOnly = 1'b1;
    if (csr.adr == `TIME_ADR) begin  // Sits in the alias range at slot 1
      readValue   = mtime[31:0];
      machineOnly = 1'b0;
    end else if (csr.adr == `TIMEH_ADR) begin
      readValue   = mtime[63:32];
      machineOnly = 1'b0;
    end else if (csr.adr[11:IdxW] == MLowBase[11:IdxW]) begin
      readValue = counterLow[idx];
    end else if (csr.adr[11:IdxW] == MHighBase[11:IdxW]) begin
      readValue = counterHigh[idx];
    end else if (csr.adr[11:IdxW] == ULowBase[11:IdxW]) begin
      readValue   = counterLow[idx];   // User alias
      machineOnly = 1'b0;
    end else if (csr.adr[11:IdxW] == UHighBase[11:IdxW]) begin
      readValue   = counterHigh[idx];
      machineOnly = 1'b0;
    end else if (csr.adr == `MCOUNTINHIBIT_ADR) begin
      readValue[`COUNTERS-1:0] = inhibitMask;  // Upper bits read zero
    end else if (csr.adr == `MCOUNTEREN_ADR) begin
      readValue[`COUNTERS-1:0] = mEnableMask;
    end else if (csr.adr == `SCOUNTEREN_ADR) begin
      readValue[`COUNTERS-1:0] = sEnableMask;
    end else begin
      known = 1'b0;  // Nothing here
    end
  end

  // Lower modes need mcounteren, user mode also scounteren
  always_comb begin
    case (csr.priv)
      counterPkg::privMachine:    allowed = known;
      counterPkg::privSupervisor: allowed = known & ~machineOnly & mEnableMask[idx];
      counterPkg::privUser:       allowed = known & ~machineOnly & mEnableMask[idx]
                                                  & sEnableMask[idx];
      default:                    allowed = 1'b0;  // Reserved mode
    endcase
  end

  assign readData      = allowed ? readValue : '0;
  assign illegalAccess = ~allowed;

endmodule

`default_nettype wire

// File: logic/machineTimer.sv
// Machine timer: free-running 64-bit mtime that ticks once per prescale period
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module machineTimer (
  input  wire logic  clk,
  input  wire logic  reset,
  output logic [63:0] mtime
);

  localparam int PreW = (`TIMER_DIVIDE > 1) ? $clog2(`TIMER_DIVIDE) : 1;

  logic [PreW-1:0] prescale;  // Cycles into the current tick
  logic            tick;

  assign tick = (prescale == PreW'(`TIMER_DIVIDE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      prescale <= '0;
      mtime    <= '0;
    end else begin
      prescale <= tick ? '0 : prescale + 1'b1;  // Wrap at end of period
      if (tick) mtime <= mtime + 64'd1;
    end
  end

endmodule

`default_nettype wire

// File: logic/perfCounters.sv
// Performance counter top: event source, control masks, counter bank, timer and read mux
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module perfCounters (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   stallE,
  input  wire logic                   stallM,
  input  wire logic                   flushM,
  input  wire logic                   loadStallD,
  input  wire counterPkg::pipeEventsT  pipe,
  input  wire counterPkg::cacheEventsT cache,
  input  wire counterPkg::csrAccessT   csr,
  output logic [`XLEN-1:0]            readData,
  output logic                        illegalAccess
);

  logic [`COUNTERS-1:0] counterEvent;  // One strobe per slot
  logic [`COUNTERS-1:0] inhibitMask;
  logic [`COUNTERS-1:0] mEnableMask;
  logic [`COUNTERS-1:0] sEnableMask;
  logic [`XLEN-1:0]     counterLow  [`COUNTERS];
  logic [`XLEN-1:0]     counterHigh [`COUNTERS];
  logic [63:0]          mtime;

  eventSource eventSource_inst (.clk, .reset, .stallE, .stallM, .flushM, .loadStallD,
                                .pipe, .cache, .counterEvent);

  counterControl counterControl_inst (.clk, .reset, .csr, .inhibitMask, .mEnableMask,
                                      .sEnableMask);

  counterBank counterBank_inst (.clk, .reset, .csr, .counterEvent, .inhibitMask,
                                .counterLow, .counterHigh);

  machineTimer machineTimer_inst (.clk, .reset, .mtime);

  counterRead counterRead_inst (.csr, .counterLow, .counterHigh, .mtime, .inhibitMask,
                                .mEnableMask, .sEnableMask, .readData, .illegalAccess);

endmodule

`default_nettype wire

// File: verification/perfCountersTb.sv
// Performance counter testbench with directed tests checked against a rule-based reference model
`timescale 1ns/1ps
`default_nettype none

`include "counters_defines.svh"

module perfCountersTb;

  localparam int ResetCycles   = 16;
  localparam int EventCycles   = 200;
  localparam int InhibitCycles = 100;
  // Four times the reset, both event runs and about 150 cycles of CSR traffic
  localparam int TimeoutCycles = 4 * (ResetCycles + EventCycles + InhibitCycles + 150);

  logic                    clk;
  logic                    reset;
  logic                    stallE;
  logic                    stallM;
  logic                    flushM;
  logic                    loadStallD;
  counterPkg::pipeEventsT  pipe;
  counterPkg::cacheEventsT cache;
  counterPkg::csrAccessT   csr;
  logic [`XLEN-1:0]        readData;
  logic                    illegalAccess;

  logic [63:0]          refCount [`COUNTERS];  // Expected counter values
  logic [`COUNTERS-1:0] refInhibit;            // Expected inhibit mask
  logic                 refLdE;                // Load stall in E
  logic                 refLdM;                // Load stall in M
  int unsigned          cyclesRun;             // Edges since reset release
  int                   errorCount;
  int                   checkCount;
  logic [31:0]          rngState;

  perfCounters perfCounters_inst (.clk, .reset, .stallE, .stallM, .flushM, .loadStallD,
                                  .pipe, .cache, .csr, .readData, .illegalAccess);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    errorCount++;
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("Summary: %0d checks run, %0d errors", checkCount, errorCount);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // Reference model sampled at each edge
  ////////////////////////////////////////
  always @(posedge clk) begin : refModel
    logic [`COUNTERS-1:0] ev;
    logic                 retire;
    logic [63:0]          nextValue;
    if (reset) begin
      for (int i = 0; i < `COUNTERS; i++) begin
        refCount[i] <= '0;
      end
      refInhibit <= '0;
      refLdE     <= 1'b0;
      refLdM     <= 1'b0;
      cyclesRun  <= 0;
    end else begin
      cyclesRun <= cyclesRun + 1;
      retire = pipe.instrValid & ~pipe.stallW & ~pipe.flushW;
      ev = '0;
      ev[counterPkg::cycleIdx]        = 1'b1;
      ev[counterPkg::instretIdx]      = retire;
      ev[counterPkg::loadStallIdx]    = refLdM;  // Third edge after D
      ev[counterPkg::branchDirIdx]    = pipe.branchDirWrong & retire;
      ev[counterPkg::dCacheAccessIdx] = cache.dCacheAccess;
      ev[counterPkg::dCacheMissIdx]   = cache.dCacheMiss;
      ev[counterPkg::iCacheMissIdx]   = cache.iCacheMiss;
      for (int i = 0; i < `COUNTERS; i++) begin
        nextValue = refCount[i] + 64'(ev[i] & ~refInhibit[i]);
        if (csr.writeEn && csr.adr == `MHPMCOUNTER_BASE + 12'(i)) begin
          nextValue[31:0] = csr.writeData;  // Low half replaced
        end
        if (csr.writeEn && csr.adr == `MHPMCOUNTERH_BASE + 12'(i)) begin
          nextValue[63:32] = csr.writeData;  // High half replaced
        end
        refCount[i] <= nextValue;
      end
      if (csr.writeEn && csr.adr == `MCOUNTINHIBIT_ADR) refInhibit <= csr.writeData[7:0];
      refLdE <= stallE ? refLdE : loadStallD;
      refLdM <= flushM ? 1'b0 : (stallM ? refLdM : refLdE);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] randomWord();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("MISMATCH time=%0d ns signal=%s got=%h expected=%h", $time, name, got, expected);
    end
  endtask

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////
  task automatic writeCsr(input logic [11:0] adr, input logic [31:0] data);
    @(posedge clk);
    #1;
    csr.writeEn   = 1'b1;
    csr.adr       = adr;
    csr.writeData = data;
    csr.priv      = counterPkg::privMachine;
    @(posedge clk);
    #1;
    csr.writeEn = 1'b0;  // One write per call
  endtask

  // Combinational read sampled mid cycle
  task automatic readCsr(input logic [11:0] adr, input counterPkg::privModeT priv,
                         output logic [31:0] data, output logic illegal);
    @(posedge clk);
    #1;
    csr.writeEn = 1'b0;
    csr.adr     = adr;
    csr.priv    = priv;
    #4;
    data    = readData;
    illegal = illegalAccess;
  endtask

  task automatic runEvents(input int cycles, input logic withStalls);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      r = randomWord();
      pipe.instrValid     = r[0] | r[1];  // Mostly valid
      pipe.stallW         = withStalls & r[2] & r[3];
      pipe.flushW         = withStalls & r[4] & r[5];
      pipe.branchDirWrong = r[6];
      cache               = r[10:7];
      loadStallD          = r[11];
    end
    @(posedge clk);
    #1;
    pipe       = '0;
    cache      = '0;
    loadStallD = 1'b0;
  endtask

  task automatic checkCounter(input int i);
    logic [31:0] data;
    logic        illegal;
    readCsr(`MHPMCOUNTER_BASE + 12'(i), counterPkg::privMachine, data, illegal);
    compareValue($sformatf("mhpmcounter%0d", i), data, refCount[i][31:0]);
    compareValue($sformatf("mhpmcounter%0d illegalAccess", i), illegal, 1'b0);
    readCsr(`MHPMCOUNTERH_BASE + 12'(i), counterPkg::privMachine, data, illegal);
    compareValue($sformatf("mhpmcounterh%0d", i), data, refCount[i][63:32]);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic resetAndCycleCount();
    logic [31:0] data;
    logic        illegal;
    readCsr(`MHPMCOUNTER_BASE, counterPkg::privMachine, data, illegal);
    compareValue("mcycle", data, cyclesRun);
    readCsr(12'h7C0, counterPkg::privMachine, data, illegal);  // Nothing mapped here
    compareValue("unmapped readData", data, 0);
    compareValue("unmapped illegalAccess", illegal, 1'b1);
    checkCounter(counterPkg::unusedIdx);
  endtask

  task automatic randomEventCounts();
    runEvents(EventCycles, 1'b1);
    for (int i = 0; i < `COUNTERS; i++) checkCounter(i);
  endtask

  task automatic inhibitedCountersFreeze();
    logic [31:0] mask;
    logic [31:0] data;
    logic        illegal;
    logic [63:0] frozen [`COUNTERS];
    mask = (randomWord() & 32'hFC) | 32'h08;  // Cycle counter keeps running
    writeCsr(`MCOUNTINHIBIT_ADR, mask);
    readCsr(`MCOUNTINHIBIT_ADR, counterPkg::privMachine, data, illegal);
    compareValue("mcountinhibit", data, mask);
    frozen = refCount;
    runEvents(InhibitCycles, 1'b0);
    for (int i = 0; i < `COUNTERS; i++) begin
      checkCounter(i);
      readCsr(`MHPMCOUNTER_BASE + 12'(i), counterPkg::privMachine, data, illegal);
      if (mask[i]) compareValue($sformatf("frozen mhpmcounter%0d", i), data, frozen[i][31:0]);
    end
    writeCsr(`MCOUNTINHIBIT_ADR, 0);
  endtask

  task automatic splitWriteCarry();
    logic [31:0] v;
    logic [31:0] data;
    logic        illegal;
    v = randomWord();
    writeCsr(`MHPMCOUNTERH_BASE + 12'(counterPkg::dCacheAccessIdx), v);  // High first
    writeCsr(`MHPMCOUNTER_BASE + 12'(counterPkg::dCacheAccessIdx), 32'hFFFF_FFFF);
    @(posedge clk);
    #1;
    cache.dCacheAccess = 1'b1;  // One counted cycle
    @(posedge clk);
    #1;
    cache.dCacheAccess = 1'b0;
    readCsr(`MHPMCOUNTER_BASE + 12'(counterPkg::dCacheAccessIdx), counterPkg::privMachine,
            data, illegal);
    compareValue("carry low word", data, 0);
    readCsr(`MHPMCOUNTERH_BASE + 12'(counterPkg::dCacheAccessIdx), counterPkg::privMachine,
            data, illegal);
    compareValue("carry high word", data, 32'(v + 32'd1));
  endtask

  task automatic privilegedReads();
    logic [31:0]           r;
    logic [7:0]            mEn;
    logic [7:0]            sEn;
    logic [11:0]           adr;
    logic [31:0]           data;
    logic [31:0]           half;
    logic                  illegal;
    logic                  allowed;
    counterPkg::privModeT  priv;
    r   = randomWord();
    mEn = (r[7:0] | 8'h07) & ~8'h08;   // Slot 3 denied to lower modes
    sEn = (r[15:8] | 8'h02) & ~8'h04;  // Slot 2 denied to user only
    writeCsr(`MCOUNTEREN_ADR, 32'(mEn));
    writeCsr(`SCOUNTEREN_ADR, 32'(sEn));
    for (int i = 0; i < `COUNTERS; i++) begin
      for (int h = 0; h < 2; h++) begin
        for (int p = 0; p < 2; p++) begin
          priv    = (p == 0) ? counterPkg::privSupervisor : counterPkg::privUser;
          adr     = ((h == 0) ? `HPMCOUNTER_BASE : `HPMCOUNTERH_BASE) + 12'(i);
          allowed = mEn[i] & ((p == 0) | sEn[i]);
          readCsr(adr, priv, data, illegal);
          if (i == counterPkg::unusedIdx) begin  // Slot 1 aliases are time and timeh
            half = (h == 0) ? 32'(cyclesRun / `TIMER_DIVIDE) : 32'd0;
          end else begin
            half = (h == 0) ? refCount[i][31:0] : refCount[i][63:32];
          end
          compareValue($sformatf("illegalAccess %h mode %0d", adr, priv), illegal, !allowed);
          compareValue($sformatf("readData %h mode %0d", adr, priv), data, allowed ? half : 0);
        end
      end
    end
    readCsr(`MHPMCOUNTER_BASE + 12'd2, counterPkg::privSupervisor, data, illegal);
    compareValue("minstret from supervisor", {illegal, data}, {1'b1, 32'd0});
    readCsr(`MCOUNTEREN_ADR, counterPkg::privUser, data, illegal);
    compareValue("mcounteren from user", {illegal, data}, {1'b1, 32'd0});
    readCsr(`MCOUNTEREN_ADR, counterPkg::privMachine, data, illegal);
    compareValue("mcounteren", data, mEn);
  endtask

  task automatic timeShadow();
    logic [31:0] t0;
    logic [31:0] t1;
    logic        illegal;
    readCsr(`TIME_ADR, counterPkg::privMachine, t0, illegal);
    compareValue("time since reset", t0, cyclesRun / `TIMER_DIVIDE);
    repeat (39) @(posedge clk);  // Read below adds the 40th edge
    readCsr(`TIME_ADR, counterPkg::privMachine, t1, illegal);
    compareValue("time delta", t1 - t0, 40 / `TIMER_DIVIDE);
    readCsr(`TIMEH_ADR, counterPkg::privMachine, t1, illegal);
    compareValue("timeh", t1, 0);
  endtask

  initial begin
    reset      = 1'b1;
    stallE     = 1'b0;
    stallM     = 1'b0;
    flushM     = 1'b0;
    loadStallD = 1'b0;
    pipe       = '0;
    cache      = '0;
    csr        = '0;
    errorCount = 0;
    checkCount = 0;
    rngState   = 32'h8858_9bc0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    resetAndCycleCount();
    randomEventCounts();
    inhibitedCountersFreeze();
    splitWriteCarry();
    privilegedReads();
    timeShadow();
    $display("Summary: %0d checks run, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
logic/counterPkg.sv
logic/eventSource.sv
logic/counterControl.sv
logic/counterBank.sv
logic/counterRead.sv
logic/machineTimer.sv
logic/perfCounters.sv
verification/perfCountersTb.sv
